/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;                 // Data and address width
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_DEPTH = 64;                 // Instruction words
    localparam int DMEM_DEPTH = 64;                 // Data words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // Word index bits
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // Forwards operand B, used by lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4      // Link address for jal and jalr
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, viewed in each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

/* logic/ctrl_if.sv */
interface ctrl_if;
    import rv_pkg::*;

    logic                  reg_write;
    logic                  alu_src_imm;   // Immediate as operand B
    alu_op_e               alu_op;
    wb_sel_e               wb_sel;
    logic                  mem_write;
    logic [XLEN-1:0]       imm;           // Sign extended immediate
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  is_branch;
    logic                  branch_ne;     // Set for bne
    logic                  is_jal;
    logic                  is_jalr;

    modport dec (output reg_write, alu_src_imm, alu_op, wb_sel, mem_write, imm,
                        rs1, rs2, rd, is_branch, branch_ne, is_jal, is_jalr);
    modport dp  (input  reg_write, alu_src_imm, alu_op, wb_sel, imm, rs1, rs2, rd);
    modport pc  (input  imm, is_jal, is_jalr);

endinterface

/* logic/instr_mem.sv */
module instr_mem (
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    output logic [rv_pkg::XLEN-1:0] instr_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]    rom [IMEM_DEPTH];
    logic [IMEM_AW-1:0] word_idx;
    logic               in_range;

    initial begin
        $readmemh("testbench/program.hex", rom);
    end

    assign word_idx = addr_i[IMEM_AW+1:2];            // Byte address to word index
    assign in_range = (addr_i[XLEN-1:IMEM_AW+2] == '0);

    // Fetch past the end yields an all zero word
    always_comb begin
        if (in_range) begin
            instr_o = rom[word_idx];
        end else begin
            instr_o = '0;
        end
    end

endmodule

/* logic/control_unit.sv */
module control_unit (
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic                    eq_i,
    output logic                    take_branch_o,
    output logic [rv_pkg::XLEN-1:0] instr_o,
    ctrl_if.dec                     ctrl
);
    import rv_pkg::*;

    instr_u ins;

    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b111:  return ALU_AND;
            3'b110:  return ALU_OR;
            3'b100:  return ALU_XOR;
            3'b010:  return ALU_SLT;
            3'b001:  return ALU_SLL;
            3'b101:  return ALU_SRL;
            default: return ALU_ADD;
        endcase
    endfunction

    instr_mem u_imem (
        .addr_i  (pc_i),
        .instr_o (instr_o)
    );

    assign ins = instr_o;

    // Register indices sit at the same bits in every format
    assign ctrl.rs1 = ins.r_fmt.rs1;
    assign ctrl.rs2 = ins.r_fmt.rs2;
    assign ctrl.rd  = ins.r_fmt.rd;

    always_comb begin
        ctrl.reg_write   = 1'b0;   // Unknown opcodes write nothing
        ctrl.alu_src_imm = 1'b0;
        ctrl.alu_op      = ALU_ADD;
        ctrl.wb_sel      = WB_ALU;
        ctrl.mem_write   = 1'b0;
        ctrl.imm         = '0;
        ctrl.is_branch   = 1'b0;
        ctrl.branch_ne   = 1'b0;
        ctrl.is_jal      = 1'b0;
        ctrl.is_jalr     = 1'b0;
        case (ins.r_fmt.opcode)
            OP_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(ins.r_fmt.funct3, ins.r_fmt.funct7[5]);
            end
            OP_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_from_funct(ins.r_fmt.funct3, 1'b0);
                ctrl.imm         = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // Address is rs1 plus offset
                ctrl.wb_sel      = WB_MEM;
                ctrl.imm         = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
            end
            OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5,
                                    ins.s_fmt.imm_4_0};
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = ins.r_fmt.funct3[0];   // beq is 000, bne is 001
                ctrl.imm       = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                                  ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.imm         = {ins.u_fmt.imm_31_12, 12'b0};
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                ctrl.is_jal    = 1'b1;
                ctrl.imm       = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                                  ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
            end
            OP_JALR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.wb_sel      = WB_PC4;
                ctrl.is_jalr     = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // Target from rs1 plus offset
                ctrl.imm         = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
            end
            default: ;
        endcase
    end

    assign take_branch_o = ctrl.is_branch & (eq_i ^ ctrl.branch_ne);

    // No instruction of the subset writes both the register file and memory
    always_comb begin
        a_single_write: assert (!(ctrl.reg_write && ctrl.mem_write))
            else $error("decoder set reg_write and mem_write together");
    end

endmodule

/* logic/reg_alu.sv */
module reg_alu (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    ctrl_if.dp                      ctrl,
    input  logic [rv_pkg::XLEN-1:0] pc_plus4_i,
    input  logic [rv_pkg::XLEN-1:0] mem_rdata_i,
    output logic                    eq_o,
    output logic [rv_pkg::XLEN-1:0] alu_result_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o,
    output logic [rv_pkg::XLEN-1:0] a0_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];   // x0 is not stored
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] wb_data;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && (ctrl.rd != '0)) begin
            regs[ctrl.rd] <= wb_data;
        end
    end

    assign rs1_data   = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2_data_o = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];
    assign a0_o       = regs[10];

    assign eq_o = (rs1_data == rs2_data_o);         // Compared for beq and bne
    assign op_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data_o;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result_o = rs1_data + op_b;
            ALU_SUB:    alu_result_o = rs1_data - op_b;
            ALU_AND:    alu_result_o = rs1_data & op_b;
            ALU_OR:     alu_result_o = rs1_data | op_b;
            ALU_XOR:    alu_result_o = rs1_data ^ op_b;
            ALU_SLT:    alu_result_o = {31'b0, $signed(rs1_data) < $signed(op_b)};
            ALU_SLL:    alu_result_o = rs1_data << op_b[4:0];
            ALU_SRL:    alu_result_o = rs1_data >> op_b[4:0];
            ALU_PASS_B: alu_result_o = op_b;
            default:    alu_result_o = '0;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata_i;
            WB_PC4:  wb_data = pc_plus4_i;   // Link address
            default: wb_data = alu_result_o;
        endcase
    end

    // A write aimed at x0 leaves it reading zero in the next cycle
    a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ctrl.reg_write && (ctrl.rd == '0)) |=> ((ctrl.rs1 != '0) || (rs1_data == '0)))
        else $error("x0 read back nonzero after a write");

endmodule

/* logic/pc_unit.sv */
module pc_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    ctrl_if.pc                      ctrl,
    input  logic                    take_branch_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] pc_plus4_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] next_pc;

    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_result_i[XLEN-1:1], 1'b0};   // rs1 plus offset, bit 0 cleared
        end else if (take_branch_i || ctrl.is_jal) begin
            next_pc = pc_o + ctrl.imm;                  // PC relative target
        end else begin
            next_pc = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
        end else begin
            pc_o <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc_o);

endmodule

/* logic/data_mem.sv */
module data_mem (
    input  logic                    clk_i,
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    input  logic                    we_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i,
    output logic [rv_pkg::XLEN-1:0] rdata_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]    ram [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;

    assign word_idx = addr_i[DMEM_AW+1:2];   // Upper bits wrap around
    assign rdata_o  = ram[word_idx];         // Combinational read for lw

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            ram[word_idx] <= wdata_i;
        end
    end

    // Only full words are stored
    a_word_store: assert property (@(posedge clk_i)
        we_i |-> (addr_i[1:0] == 2'b00))
        else $error("misaligned store to %h", addr_i);

endmodule

/* logic/cpu_top.sv */
module cpu_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    output logic [rv_pkg::XLEN-1:0] instr_o,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic                    mem_write_o,
    output logic [rv_pkg::XLEN-1:0] a0_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] mem_rdata;
    logic            eq;
    logic            take_branch;

    ctrl_if ctrl_bus ();

    assign mem_write_o = ctrl_bus.mem_write & rst_n_i;   // No stores during reset

    control_unit u_ctrl (
        .pc_i          (pc_o),
        .eq_i          (eq),
        .take_branch_o (take_branch),
        .instr_o       (instr_o),
        .ctrl          (ctrl_bus.dec)
    );

    reg_alu u_reg_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl         (ctrl_bus.dp),
        .pc_plus4_i   (pc_plus4),
        .mem_rdata_i  (mem_rdata),
        .eq_o         (eq),
        .alu_result_o (alu_result),
        .rs2_data_o   (rs2_data),
        .a0_o         (a0_o)
    );

    pc_unit u_pc (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ctrl          (ctrl_bus.pc),
        .take_branch_i (take_branch),
        .alu_result_i  (alu_result),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4)
    );

    data_mem u_dmem (
        .clk_i   (clk_i),
        .addr_i  (alu_result),
        .we_i    (mem_write_o),
        .wdata_i (rs2_data),
        .rdata_o (mem_rdata)
    );

endmodule

/* testbench/tb_cpu.sv */
module tb_cpu;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 400;   // Tests take about 80 cycles

    // Program words that the checks look for
    localparam logic [31:0] WORD_ADDI_5 = 32'h00500513;   // addi a0, x0, 5
    localparam logic [31:0] WORD_SW     = 32'h00A02823;   // sw a0, 16(x0)
    localparam logic [31:0] WORD_JAL    = 32'h0080056F;   // jal a0, +8

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        mem_write;
    logic [31:0] a0;

    int error_count;
    int cycle_count;

    cpu_top u_cpu_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .instr_o     (instr),
        .pc_o        (pc),
        .mem_write_o (mem_write),
        .a0_o        (a0)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation timed out before tests finished");
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else begin
            error_count++;
            $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(negedge clk);   // One instruction per rising edge
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #1;
    endtask

    task automatic reset_test();
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("reset_test", "pc", 32'd0, pc);
            check_value("reset_test", "mem_write", 32'd0, {31'b0, mem_write});
            check_value("reset_test", "instr", WORD_ADDI_5, instr);
        end
        rst_n = 1'b1;
        #1;
        check_value("reset_test", "pc", 32'd0, pc);   // Still at the first word
        check_value("reset_test", "mem_write", 32'd0, {31'b0, mem_write});
        check_value("reset_test", "instr", WORD_ADDI_5, instr);
    endtask

    task automatic alu_test();
        logic [31:0] expected_a0 [5] = '{32'd5, 32'd12, 32'd9, 32'd8, 32'd32};
        apply_reset();
        for (int i = 0; i < 5; i++) begin
            step_cycles(1);
            check_value("alu_test", "a0", expected_a0[i], a0);
            check_value("alu_test", "pc", 32'(4 * (i + 1)), pc);
        end
    endtask

    task automatic mem_test();
        apply_reset();
        for (int k = 0; k <= 8; k++) begin
            check_value("mem_test", "pc", 32'(4 * k), pc);
            check_value("mem_test", "mem_write", {31'b0, k == 5}, {31'b0, mem_write});
            if (k == 5) begin
                check_value("mem_test", "instr", WORD_SW, instr);
            end
            if (k == 7) begin
                check_value("mem_test", "a0", 32'd1, a0);    // After the overwrite
            end
            if (k == 8) begin
                check_value("mem_test", "a0", 32'd32, a0);   // Loaded back from address 16
            end
            if (k < 8) begin
                step_cycles(1);
            end
        end
    endtask

    task automatic branch_test();
        apply_reset();
        step_cycles(8);   // Straight line code up to the loop
        for (int iter = 0; iter < 3; iter++) begin
            check_value("branch_test", "a0", 32'(32 + iter), a0);
            for (int j = 0; j < 4; j++) begin
                check_value("branch_test", "pc", 32'(32 + 4 * j), pc);
                step_cycles(1);
            end
        end
        check_value("branch_test", "pc", 32'd48, pc);   // Falls out after the third pass
        check_value("branch_test", "a0", 32'd35, a0);
    endtask

    task automatic jump_test();
        apply_reset();
        step_cycles(20);
        check_value("jump_test", "pc", 32'd48, pc);
        check_value("jump_test", "instr", WORD_JAL, instr);
        step_cycles(1);
        check_value("jump_test", "pc", 32'd56, pc);
        check_value("jump_test", "a0", 32'd52, a0);   // Link address from jal
        step_cycles(1);
        check_value("jump_test", "pc", 32'd52, pc);   // jalr back through a0
        check_value("jump_test", "a0", 32'd52, a0);
        step_cycles(1);
        check_value("jump_test", "pc", 32'd52, pc);   // Halt loop on word 13
        check_value("jump_test", "a0", 32'd52, a0);
    endtask

    initial begin
        rst_n = 1'b0;
        reset_test();
        alu_test();
        mem_test();
        branch_test();
        jump_test();
        $display("tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/program.hex */
// One 32-bit instruction word in hex per line, then its assembly
// Line n holds the word at byte address 4*n
00500513  // 0x00 addi a0, x0, 5
00750513  // 0x04 addi a0, a0, 7
FFD50513  // 0x08 addi a0, a0, -3
00C57513  // 0x0c andi a0, a0, 12
00251513  // 0x10 slli a0, a0, 2
00A02823  // 0x14 sw   a0, 16(x0)
00100513  // 0x18 addi a0, x0, 1
01002503  // 0x1c lw   a0, 16(x0)
00150513  // 0x20 addi a0, a0, 1
00128293  // 0x24 addi t0, t0, 1
00300313  // 0x28 addi t1, x0, 3
FE629AE3  // 0x2c bne  t0, t1, -12
0080056F  // 0x30 jal  a0, +8
0000006F  // 0x34 jal  x0, 0
00050067  // 0x38 jalr x0, 0(a0)

/* sim.f */
logic/rv_pkg.sv
logic/ctrl_if.sv
logic/instr_mem.sv
logic/control_unit.sv
logic/reg_alu.sv
logic/pc_unit.sv
logic/data_mem.sv
logic/cpu_top.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu -f sim.f \
    --Mdir obj_dir -o tb_cpu_sim || exit 1
out=$(./obj_dir/tb_cpu_sim)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$" && exit 0 || exit 1
